/* Bender.yml */
package:
  name: eeprom_host

sources:
  - include_dirs:
      - .
    files:
      - eeprom_pkg.sv
      - eeprom_bit_engine.sv
      - eeprom_sequencer.sv
      - eeprom_host_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - eeprom_mem_model.sv
      - eeprom_host_tb.sv

/* eeprom_bit_engine.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_bit_engine import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  bit_op_t  op,
    input  ee_byte_t tx_byte,
    input  logic     sda_in,
    output logic     op_done,
    output ee_byte_t rx_byte,
    output logic     ack_seen,
    output logic     scl,
    output logic     sda_low
);

    localparam logic [4:0] START_LAST = 5'd3;
    localparam logic [4:0] STOP_LAST  = 5'd2;
    localparam logic [4:0] DATA_STEPS = 5'(2 * `EE_DATA_W);  // two halves per bit
    localparam logic [4:0] ACK_STEP   = 5'(2 * `EE_DATA_W + 1);
    localparam logic [4:0] BYTE_LAST  = 5'(2 * `EE_DATA_W + 2);

    logic       active;
    bit_op_t    cur_op;
    logic [4:0] cnt;        // half scl periods into the command
    logic [4:0] last_step;
    logic       is_byte;
    logic       sda_drive;  // wanted SDA pull, goes out half a CLK later
    ee_byte_t   shreg;

    assign is_byte = (cur_op == OP_SEND) || (cur_op == OP_RECV);
    assign rx_byte = shreg;

    always_comb
    begin
        case (cur_op)
            OP_START: last_step = START_LAST;
            OP_STOP:  last_step = STOP_LAST;
            default:  last_step = BYTE_LAST;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            cur_op    <= OP_NONE;
            cnt       <= '0;
            scl       <= 1'b1;
            sda_drive <= 1'b0;
            op_done   <= 1'b0;
            ack_seen  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op != OP_NONE)
                begin
                    active <= 1'b1;
                    cur_op <= op;
                    cnt    <= '0;
                end
            end
            else
            begin
                cnt <= cnt + 5'd1;
                case (cur_op)
                    OP_START:
                        case (cnt)
                            5'd0:    sda_drive <= 1'b0;  // release first, repeated start
                            5'd1:    scl <= 1'b1;
                            5'd2:    sda_drive <= 1'b1;  // falls while scl high
                            default: scl <= 1'b0;
                        endcase
                    OP_STOP:
                        case (cnt)
                            5'd0:
                            begin
                                scl       <= 1'b0;
                                sda_drive <= 1'b1;
                            end
                            5'd1:    scl <= 1'b1;
                            default: sda_drive <= 1'b0;  // rises while scl high
                        endcase
                    default:
                    begin
                        scl <= cnt[0];  // even steps low, odd high
                        if (!cnt[0])
                            sda_drive <= (cur_op == OP_SEND) && (cnt < DATA_STEPS)
                                         && !shreg[`EE_DATA_W-1];
                        if (cnt == ACK_STEP)
                            ack_seen <= !sda_in;
                    end
                endcase
                if (cnt == last_step)
                begin
                    active  <= 1'b0;
                    op_done <= 1'b1;
                end
            end
        end
    end

    // msb out first, sampled bits come in at the bottom
    always_ff @(posedge CLK)
    begin
        if (!active && op != OP_NONE)
            shreg <= tx_byte;
        else if (active && is_byte && cnt[0] && cnt < DATA_STEPS)
            shreg <= {shreg[`EE_DATA_W-2:0], sda_in};
    end

    // SDA moves in the middle of an scl half, never on an scl edge
    always_ff @(negedge CLK)
    begin
        if (RESET)
            sda_low <= 1'b0;
        else
            sda_low <= sda_drive;
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        op_done |=> !op_done);

    a_sda_setup: assert property (@(posedge CLK) disable iff (RESET)
        (active && cur_op == OP_SEND && $changed(sda_low)) |-> !scl);

    a_no_overlap: assert property (@(posedge CLK) disable iff (RESET)
        active |-> op == OP_NONE);

endmodule

/* eeprom_defs.svh */
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// 2 Kbyte part, 11 bit byte address
`define EE_ADDR_W   11

// bytes on the bus and in the array
`define EE_DATA_W   8

// device type code, upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

// address bits above the word address byte form the page number
// and ride in the control byte between the type code and the r/w bit
// so EE_ADDR_W - EE_DATA_W must stay 3 for an 8 bit control byte

`endif

/* eeprom_host_tb.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_host_tb import eeprom_pkg::*;
();

    localparam int NUM_STEPS   = 23;
    localparam int CYCLE_LIMIT = NUM_STEPS * 300;

    typedef struct packed {
        logic     is_wr;
        ee_addr_t addr;
        ee_byte_t wdata;
        logic     intf;       // second write strobe while busy
        ee_addr_t intf_addr;
        ee_byte_t intf_data;
        ee_byte_t exp_rdata;
        logic     exp_nack;
    } step_t;

    logic        CLK;
    logic        RESET;
    ee_req_t     req;
    ee_status_t  status;
    logic        busy;
    logic        scl;
    wire         sda;

    step_t       steps [NUM_STEPS];
    ee_byte_t    sb_mem [0:(1 << `EE_ADDR_W) - 1];
    int          n_steps    = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    int          done_total = 0;
    int          cycles     = 0;
    int unsigned seed;

    tb_clock_gen #(.PERIOD(4.0)) clock_inst (.CLK(CLK));

    eeprom_host_top eeprom_host_top_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req),
        .status (status),
        .busy   (busy),
        .scl    (scl),
        .sda    (sda)
    );

    pullup (sda);

    eeprom_mem_model mem_inst (
        .scl (scl),
        .sda (sda)
    );

    always @(posedge status.done)
        done_total = done_total + 1;

    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT)
            begin
                $display("timeout, the run passed %0d cycles without finishing", CYCLE_LIMIT);
                $display("errors: %0d value, %0d other", value_errs, other_errs);
                $display("Verification failed");
                $finish;
            end
        end
    end

    task automatic check_byte(input string name, input ee_byte_t got, input ee_byte_t exp);
        if (got !== exp)
        begin
            value_errs++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errs++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // expected values follow the memory rules, intf strobes leave the copy alone
    task automatic add_step(input logic is_wr, input ee_addr_t addr,
                            input logic intf, input ee_addr_t intf_addr);
        step_t s;
        s           = '0;
        s.is_wr     = is_wr;
        s.addr      = addr;
        s.wdata     = ee_byte_t'($urandom);
        s.intf      = intf;
        s.intf_addr = intf_addr;
        s.intf_data = ~s.wdata;
        if (is_wr)
        begin
            s.exp_nack = (addr[`EE_ADDR_W-1:`EE_DATA_W] == 3'd7);
            if (!s.exp_nack)
                sb_mem[addr] = s.wdata;
        end
        else
            s.exp_rdata = sb_mem[addr];
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic run_step(input int idx);
        step_t s;
        int    exp_done;
        s        = steps[idx];
        exp_done = done_total + 1;
        @(negedge CLK);
        req.wr    = s.is_wr;
        req.rd    = !s.is_wr;
        req.addr  = s.addr;
        req.wdata = s.wdata;
        @(negedge CLK);
        check_flag("busy", busy, 1'b1);
        req = '0;
        if (s.intf)
        begin
            req.wr    = 1'b1;
            req.addr  = s.intf_addr;
            req.wdata = s.intf_data;
            @(negedge CLK);
            req = '0;
        end
        while (status.done !== 1'b1)
            @(negedge CLK);
        if (!s.is_wr)
            check_byte("status.rdata", status.rdata, s.exp_rdata);
        check_flag("status.nack", status.nack, s.exp_nack);
        check_flag("busy", busy, 1'b0);
        @(negedge CLK);
        check_flag("status.done", status.done, 1'b0);
        check_flag("busy", busy, 1'b0);
        if (done_total != exp_done)
        begin
            other_errs++;
            $display("step %0d gave %0d done pulses instead of one", idx,
                     done_total - exp_done + 1);
        end
    endtask

    initial
    begin
        ee_addr_t a;
        seed = 32'ha281_057f;
        void'($urandom(seed));
        req   = '0;
        RESET = 1'b1;
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            sb_mem[i] = 8'hff;

        add_step(1'b0, 11'h0a5, 1'b0, '0);  // never written
        for (int p = 0; p < 7; p++)
        begin
            a = {p[2:0], 8'(p * 37 + 18)};
            add_step(1'b1, a, 1'b0, '0);
            add_step(1'b0, a, 1'b0, '0);
        end
        add_step(1'b1, 11'h7f0, 1'b0, '0);  // protected page
        add_step(1'b0, 11'h7f0, 1'b0, '0);
        add_step(1'b1, 11'h321, 1'b1, 11'h322);
        add_step(1'b0, 11'h321, 1'b0, '0);
        add_step(1'b0, 11'h322, 1'b0, '0);
        add_step(1'b1, 11'h012, 1'b1, 11'h137);
        add_step(1'b0, 11'h137, 1'b0, '0);  // still the page 1 data
        add_step(1'b0, 11'h012, 1'b0, '0);

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        repeat (3)
        begin
            @(negedge CLK);
            check_flag("scl", scl, 1'b1);
            check_flag("sda", sda, 1'b1);
            check_flag("busy", busy, 1'b0);
            check_flag("status.done", status.done, 1'b0);
        end

        for (int i = 0; i < n_steps; i++)
            run_step(i);
        repeat (4) @(negedge CLK);
        if (done_total != n_steps)
        begin
            other_errs++;
            $display("saw %0d done pulses for %0d requests", done_total, n_steps);
        end

        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* eeprom_host_top.sv */
`timescale 1ns/1ps

module eeprom_host_top import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  ee_req_t    req,
    output ee_status_t status,
    output logic       busy,
    output logic       scl,
    inout  wire        sda
);

    bit_op_t  op;
    ee_byte_t tx_byte;
    ee_byte_t rx_byte;
    logic     op_done;
    logic     ack_seen;
    logic     sda_low;

    eeprom_sequencer sequencer_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .op       (op),
        .tx_byte  (tx_byte),
        .status   (status),
        .busy     (busy)
    );

    eeprom_bit_engine bit_engine_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .op       (op),
        .tx_byte  (tx_byte),
        .sda_in   (sda),
        .op_done  (op_done),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .scl      (scl),
        .sda_low  (sda_low)
    );

    assign sda = sda_low ? 1'b0 : 1'bz;  // open drain, external pull-up

endmodule

/* eeprom_mem_model.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_mem_model import eeprom_pkg::*;
(
    input  logic scl,
    inout  wire  sda
);

    typedef enum logic [2:0] {P_IDLE, P_CTRL, P_ADDR, P_DATA, P_READ} phase_t;

    ee_byte_t   mem [0:(1 << `EE_ADDR_W) - 1];
    phase_t     phase;
    logic [3:0] cnt;        // rising scl edges in this byte
    logic       in_ack;
    logic       tx_armed;   // read control byte seen, data goes out next
    logic       pull;
    logic [`EE_ADDR_W-`EE_DATA_W-1:0] page;
    ee_byte_t   word;
    ee_byte_t   shreg;
    ee_byte_t   out_byte;

    assign sda = pull ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
            mem[i] = 8'hff;
        phase    = P_IDLE;
        cnt      = '0;
        in_ack   = 1'b0;
        tx_armed = 1'b0;
        pull     = 1'b0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase    = P_CTRL;
            cnt      = '0;
            in_ack   = 1'b0;
            tx_armed = 1'b0;
            pull     = 1'b0;
        end
    end

    // stop
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase    = P_IDLE;
            in_ack   = 1'b0;
            tx_armed = 1'b0;
            pull     = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE && !in_ack && cnt < 4'd8)
        begin
            shreg = {shreg[`EE_DATA_W-2:0], sda};
            cnt   = cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (in_ack)
        begin
            in_ack = 1'b0;  // end of the ack slot
            cnt    = '0;
            pull   = 1'b0;
            if (tx_armed)
            begin
                tx_armed = 1'b0;
                out_byte = mem[{page, word}];
                pull     = !out_byte[7];
            end
            else if (phase == P_READ)
                phase = P_IDLE;
        end
        else if (cnt == 4'd8 && phase != P_IDLE)
        begin
            in_ack = 1'b1;
            pull   = 1'b0;
            case (phase)
                P_CTRL:
                    if (shreg[7:4] == `EE_DEV_CODE)
                    begin
                        page     = shreg[3:1];
                        pull     = 1'b1;
                        tx_armed = shreg[0];
                        phase    = shreg[0] ? P_READ : P_ADDR;
                    end
                    else
                        phase = P_IDLE;
                P_ADDR:
                begin
                    word  = shreg;
                    pull  = 1'b1;
                    phase = P_DATA;
                end
                P_DATA:
                begin
                    if (page != '1)  // top page is write protected
                    begin
                        mem[{page, word}] = shreg;
                        pull = 1'b1;
                    end
                    phase = P_IDLE;
                end
                default: ;  // read byte done, master acks
            endcase
        end
        else if (phase == P_READ && cnt > 4'd0 && cnt < 4'd8)
            pull = !out_byte[7 - cnt];
    end

endmodule

/* eeprom_pkg.sv */
package eeprom_pkg;

    `include "eeprom_defs.svh"

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_byte_t;

    typedef struct packed {
        logic     wr;       // wins over rd when both are set
        logic     rd;
        ee_addr_t addr;
        ee_byte_t wdata;
    } ee_req_t;

    typedef struct packed {
        logic     done;     // one cycle per transaction
        logic     nack;
        ee_byte_t rdata;
    } ee_status_t;

    typedef enum logic [3:0] {
        SEQ_IDLE, SEQ_START, SEQ_CTRL_WR, SEQ_ADDR_WR, SEQ_DATA_WR,
        SEQ_RSTART, SEQ_CTRL_RD, SEQ_DATA_RD, SEQ_STOP, SEQ_DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_START,
        OP_STOP,
        OP_SEND,
        OP_RECV
    } bit_op_t;

endpackage

/* eeprom_sequencer.sv */
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module eeprom_sequencer import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  ee_req_t    req,
    input  logic       op_done,
    input  ee_byte_t   rx_byte,
    input  logic       ack_seen,
    output bit_op_t    op,
    output ee_byte_t   tx_byte,
    output ee_status_t status,
    output logic       busy
);

    seq_state_t state;
    seq_state_t nxt;
    logic       accept;
    logic       in_send;    // a byte the slave must acknowledge
    logic       is_read;
    ee_addr_t   addr_q;
    ee_byte_t   wdata_q;
    ee_byte_t   rd_q;
    ee_byte_t   rdata_q;
    logic       nack_acc;
    logic       nack_q;
    logic       done_q;
    logic [`EE_ADDR_W-`EE_DATA_W-1:0] page;

    function automatic bit_op_t entry_op(seq_state_t s);
        case (s)
            SEQ_START, SEQ_RSTART:                              return OP_START;
            SEQ_CTRL_WR, SEQ_ADDR_WR, SEQ_DATA_WR, SEQ_CTRL_RD: return OP_SEND;
            SEQ_DATA_RD:                                        return OP_RECV;
            SEQ_STOP:                                           return OP_STOP;
            default:                                            return OP_NONE;
        endcase
    endfunction

    assign busy    = (state != SEQ_IDLE) && (state != SEQ_DONE);
    assign accept  = !busy && (req.wr || req.rd);
    assign in_send = (state == SEQ_CTRL_WR) || (state == SEQ_ADDR_WR)
                     || (state == SEQ_DATA_WR) || (state == SEQ_CTRL_RD);
    assign page    = addr_q[`EE_ADDR_W-1:`EE_DATA_W];
    assign status  = '{done: done_q, nack: nack_q, rdata: rdata_q};

    // valid in the first cycle of each send phase, when op pulses
    always_comb
    begin
        case (state)
            SEQ_CTRL_WR: tx_byte = {`EE_DEV_CODE, page, 1'b0};
            SEQ_ADDR_WR: tx_byte = addr_q[`EE_DATA_W-1:0];
            SEQ_DATA_WR: tx_byte = wdata_q;
            SEQ_CTRL_RD: tx_byte = {`EE_DEV_CODE, page, 1'b1};
            default:     tx_byte = '0;
        endcase
    end

    always_comb
    begin
        nxt = state;
        case (state)
            SEQ_IDLE:    if (accept) nxt = SEQ_START;
            SEQ_DONE:    nxt = accept ? SEQ_START : SEQ_IDLE;
            SEQ_START:   if (op_done) nxt = SEQ_CTRL_WR;
            SEQ_CTRL_WR: if (op_done) nxt = ack_seen ? SEQ_ADDR_WR : SEQ_STOP;
            SEQ_ADDR_WR:
                if (op_done)
                    nxt = !ack_seen ? SEQ_STOP : (is_read ? SEQ_RSTART : SEQ_DATA_WR);
            SEQ_DATA_WR: if (op_done) nxt = SEQ_STOP;
            SEQ_RSTART:  if (op_done) nxt = SEQ_CTRL_RD;
            SEQ_CTRL_RD: if (op_done) nxt = ack_seen ? SEQ_DATA_RD : SEQ_STOP;
            SEQ_DATA_RD: if (op_done) nxt = SEQ_STOP;
            SEQ_STOP:    if (op_done) nxt = SEQ_DONE;
            default:     nxt = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= SEQ_IDLE;
            op       <= OP_NONE;
            nack_acc <= 1'b0;
            nack_q   <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            state  <= nxt;
            op     <= (nxt != state) ? entry_op(nxt) : OP_NONE;  // pulse on phase entry
            done_q <= (state == SEQ_STOP) && op_done;
            if (accept)
                nack_acc <= 1'b0;
            else if (in_send && op_done && !ack_seen)
                nack_acc <= 1'b1;
            if (state == SEQ_STOP && op_done)
                nack_q <= nack_acc;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            is_read <= !req.wr;  // both strobes set means write
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            rd_q    <= '0;
        end
        else if (state == SEQ_DATA_RD && op_done)
            rd_q <= rx_byte;
        if (state == SEQ_STOP && op_done)
            rdata_q <= rd_q;
    end

    a_busy_done: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> status.done);

endmodule

/* list.f */
+incdir+.
eeprom_pkg.sv
eeprom_bit_engine.sv
eeprom_sequencer.sv
eeprom_host_top.sv
tb_clock_gen.sv
eeprom_mem_model.sv
eeprom_host_tb.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD = 4.0
)
(
    output logic CLK
);

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2.0) CLK = ~CLK;
    end

endmodule
